// ==== sources.f ====
hw/stream_cfg_pkg.sv
hw/stream_msg_pkg.sv
hw/lane_dispatch.sv
hw/delay_lane.sv
hw/lane_merge.sv
hw/stream_throttle_top.sv
dv/stream_throttle_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the stream throttle testbench with Verilator

ROOT=$(cd "$(dirname "$0")" && pwd)
cd "$ROOT" || exit 1

BUILD_DIR=obj_dir
SIM_BIN=stream_throttle_sim
LOG=sim.log

verilator --binary --timing --assert -Wno-fatal \
  -f sources.f \
  --top-module stream_throttle_tb \
  --Mdir "$BUILD_DIR" -o "$SIM_BIN"
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

"./$BUILD_DIR/$SIM_BIN" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if grep -q '\*\*\* TEST FAILED \*\*\*' "$LOG"; then
  echo "Simulation reported failure"
  exit 1
fi

echo "Simulation finished without failure"
exit 0

// ==== dv/stream_throttle_tb.sv ====
`timescale 1ns/1ps

module stream_throttle_tb;

  import stream_cfg_pkg::*;
  import stream_msg_pkg::*;

  localparam int DEPTH      = 4;
  localparam int SEND_INTV  = 1;
  localparam int RECV_INTV  = 2;
  localparam int CLK_PERIOD = 10;
  localparam int RST_CYCLES = 4;
  localparam int NUM_MSGS   = 400;
  localparam int SEED       = 9;
  // Worst case is every message on one lane with the sink mostly stalled
  localparam int WATCHDOG_CYC = NUM_MSGS * (SEND_INTV + RECV_INTV + 2) * 4 + 100;

  // Test slots for the counters
  localparam int T_RESET = 0;
  localparam int T_DATA  = 1;
  localparam int T_SEND  = 2;
  localparam int T_RECV  = 3;
  localparam int T_HOLD  = 4;
  localparam int T_DONE  = 5;
  localparam int N_TESTS = 6;

  logic        clk;
  logic        rst;
  logic        in_val;
  logic        in_rdy;
  stream_msg_t in_msg;
  logic        out_val;
  logic        out_rdy;
  stream_msg_t out_msg;

  // Reference model, one FIFO per lane
  stream_msg_t      model_q [NUM_LANES][$];
  logic [TAG_W-1:0] next_tag [NUM_LANES];
  // Cycle of the last transfer, per lane and side
  int               last_in_cyc [NUM_LANES];
  int               last_out_cyc [NUM_LANES];
  int               chk_cnt [N_TESTS];
  int               err_cnt [N_TESTS];
  int               cyc;
  int               sent_cnt;
  int               in_cnt;
  int               out_cnt;
  // Output as seen on the previous edge
  logic             prev_stall;
  stream_msg_t      prev_out_msg;

  stream_throttle_top #(
    .DEPTH     (DEPTH),
    .SEND_INTV (SEND_INTV),
    .RECV_INTV (RECV_INTV)
  ) dut_i (
    .clk     (clk),
    .rst     (rst),
    .in_val  (in_val),
    .in_rdy  (in_rdy),
    .in_msg  (in_msg),
    .out_val (out_val),
    .out_rdy (out_rdy),
    .out_msg (out_msg)
  );

  always #(CLK_PERIOD / 2) clk = ~clk;

  // Random lane and data, tag counts up within the lane
  function automatic stream_msg_t make_msg();
    stream_msg_t m;
    m.lane = lane_id_t'($urandom % NUM_LANES);
    m.tag  = next_tag[m.lane];
    m.data = DATA_W'($urandom);
    next_tag[m.lane] = next_tag[m.lane] + 1'b1;
    return m;
  endfunction

  task automatic check_reset_low();
    chk_cnt[T_RESET]++;
    if (in_rdy !== 1'b0) begin
      err_cnt[T_RESET]++;
      $display("[ERROR] in_rdy: got %h, expected %h", in_rdy, 1'b0);
    end
    if (out_val !== 1'b0) begin
      err_cnt[T_RESET]++;
      $display("[ERROR] out_val: got %h, expected %h", out_val, 1'b0);
    end
  endtask

  task automatic report_test(input int idx, input string name);
    $display("%-18s checks %0d  errors %0d  %s", name, chk_cnt[idx], err_cnt[idx],
             (err_cnt[idx] == 0) ? "ok" : "fail");
  endtask

  // ----------------------------------------------------------------------
  // Stimulus
  // ----------------------------------------------------------------------

  always @(posedge clk) begin
    if (rst) begin
      in_val  <= 1'b0;
      out_rdy <= 1'b0;
    end else begin
      // Sink ready about three cycles in four
      out_rdy <= ($urandom % 4) != 0;
      // Word held until it transfers
      if (!in_val || in_rdy) begin
        if (sent_cnt < NUM_MSGS && ($urandom % 3) != 0) begin
          in_msg <= make_msg();
          in_val <= 1'b1;
          sent_cnt++;
        end else begin
          in_val <= 1'b0;
        end
      end
    end
  end

  // ----------------------------------------------------------------------
  // Monitor and model
  // ----------------------------------------------------------------------

  // Values read here are the ones held over the cycle before this edge
  always @(posedge clk) begin
    stream_msg_t exp_msg;
    int          lane;
    if (!rst) begin
      cyc++;
      // Input transfer, spacing then model push
      if (in_val && in_rdy) begin
        lane = int'(in_msg.lane);
        chk_cnt[T_SEND]++;
        if (cyc - last_in_cyc[lane] < SEND_INTV + 1) begin
          err_cnt[T_SEND]++;
          $display("Send pacing broken on lane %0d: transfers %0d cycles apart, minimum %0d",
                   lane, cyc - last_in_cyc[lane], SEND_INTV + 1);
        end
        last_in_cyc[lane] = cyc;
        model_q[lane].push_back(in_msg);
        in_cnt++;
      end
      // Output transfer against the lane's model head
      if (out_val && out_rdy) begin
        lane = int'(out_msg.lane);
        chk_cnt[T_DATA]++;
        if (model_q[lane].size() == 0) begin
          err_cnt[T_DATA]++;
          $display("Output transfer on lane %0d with no message pending", lane);
        end else begin
          exp_msg = model_q[lane].pop_front();
          if (out_msg !== exp_msg) begin
            err_cnt[T_DATA]++;
            $display("[ERROR] out_msg: got %h, expected %h", out_msg, exp_msg);
          end
        end
        chk_cnt[T_RECV]++;
        if (cyc - last_out_cyc[lane] < RECV_INTV + 1) begin
          err_cnt[T_RECV]++;
          $display("Receive pacing broken on lane %0d: transfers %0d cycles apart, minimum %0d",
                   lane, cyc - last_out_cyc[lane], RECV_INTV + 1);
        end
        last_out_cyc[lane] = cyc;
        out_cnt++;
      end
      // Stalled word must not move
      if (prev_stall) begin
        chk_cnt[T_HOLD]++;
        if (out_msg !== prev_out_msg) begin
          err_cnt[T_HOLD]++;
          $display("[ERROR] out_msg under stall: got %h, expected %h", out_msg, prev_out_msg);
        end
      end
      prev_stall   = out_val && !out_rdy;
      prev_out_msg = out_msg;
    end
  end

  // ----------------------------------------------------------------------
  // Sequence and report
  // ----------------------------------------------------------------------

  initial begin
    int total_chk;
    int total_err;
    int pending;
    void'($urandom(SEED));
    clk          = 1'b0;
    rst          = 1'b1;
    in_val       = 1'b0;
    in_msg       = '0;
    out_rdy      = 1'b0;
    cyc          = 0;
    sent_cnt     = 0;
    in_cnt       = 0;
    out_cnt      = 0;
    prev_stall   = 1'b0;
    prev_out_msg = '0;
    for (int l = 0; l < NUM_LANES; l++) begin
      next_tag[l]     = '0;
      last_in_cyc[l]  = -1000;
      last_out_cyc[l] = -1000;
    end
    for (int t = 0; t < N_TESTS; t++) begin
      chk_cnt[t] = 0;
      err_cnt[t] = 0;
    end

    // Three cycles in reset, then the first cycle after it
    for (int i = 0; i < RST_CYCLES; i++) begin
      @(posedge clk);
      if (i == RST_CYCLES - 1) begin
        rst <= 1'b0;
      end
      @(negedge clk);
      check_reset_low();
    end
    report_test(T_RESET, "reset");

    wait (out_cnt >= NUM_MSGS);
    // Room for a stray extra output to show up
    repeat (RECV_INTV + 4) @(posedge clk);
    report_test(T_DATA, "data and order");
    report_test(T_SEND, "send pacing");
    report_test(T_RECV, "receive pacing");
    report_test(T_HOLD, "stall hold");

    pending = 0;
    for (int l = 0; l < NUM_LANES; l++) begin
      pending += model_q[l].size();
    end
    chk_cnt[T_DONE]++;
    if (pending != 0) begin
      err_cnt[T_DONE]++;
      $display("%0d messages still pending in the model after the run", pending);
    end
    if (out_cnt != in_cnt || in_cnt != NUM_MSGS) begin
      err_cnt[T_DONE]++;
      $display("[ERROR] out_cnt: got %h, expected %h (in_cnt %h)", out_cnt, NUM_MSGS, in_cnt);
    end
    report_test(T_DONE, "completion");

    total_chk = 0;
    total_err = 0;
    for (int t = 0; t < N_TESTS; t++) begin
      total_chk += chk_cnt[t];
      total_err += err_cnt[t];
    end
    $display("Checks %0d, errors %0d, messages in %0d, out %0d",
             total_chk, total_err, in_cnt, out_cnt);
    if (total_err == 0) begin
      $display("*** TEST PASSED ***");
    end else begin
      $display("*** TEST FAILED ***");
    end
    $finish;
  end

  // Watchdog
  initial begin
    #(WATCHDOG_CYC * CLK_PERIOD);
    $display("Timeout after %0d cycles: %0d of %0d messages came out",
             WATCHDOG_CYC, out_cnt, NUM_MSGS);
    $display("*** TEST FAILED ***");
    $finish;
  end

endmodule

// ==== hw/stream_throttle_top.sv ====
`timescale 1ns/1ps

// Multi-lane stream throttle
module stream_throttle_top #(
  parameter int DEPTH     = 4,
  parameter int SEND_INTV = 1,
  parameter int RECV_INTV = 2
) (
  input  logic                        clk,
  input  logic                        rst,

  input  logic                        in_val,
  output logic                        in_rdy,
  input  stream_msg_pkg::stream_msg_t in_msg,

  output logic                        out_val,
  input  logic                        out_rdy,
  output stream_msg_pkg::stream_msg_t out_msg
);

  import stream_cfg_pkg::*;
  import stream_msg_pkg::*;

  // Dispatcher to lanes
  logic [NUM_LANES-1:0] lane_in_val;
  logic [NUM_LANES-1:0] lane_in_rdy;
  stream_msg_t          lane_in_msg;

  // Lanes to merger
  logic [NUM_LANES-1:0] lane_out_val;
  logic [NUM_LANES-1:0] lane_out_rdy;
  stream_msg_t          lane_out_msg [NUM_LANES];

  lane_dispatch dispatch_i (
    .in_val      (in_val),
    .in_rdy      (in_rdy),
    .in_msg      (in_msg),
    .lane_in_val (lane_in_val),
    .lane_in_rdy (lane_in_rdy),
    .lane_in_msg (lane_in_msg)
  );

  // One paced FIFO per lane, all sized alike
  for (genvar i = 0; i < NUM_LANES; i++) begin : g_lane
    delay_lane #(
      .DEPTH     (DEPTH),
      .SEND_INTV (SEND_INTV),
      .RECV_INTV (RECV_INTV)
    ) lane_i (
      .clk      (clk),
      .rst      (rst),
      .send_val (lane_in_val[i]),
      .send_rdy (lane_in_rdy[i]),
      .send_msg (lane_in_msg),
      .recv_val (lane_out_val[i]),
      .recv_rdy (lane_out_rdy[i]),
      .recv_msg (lane_out_msg[i])
    );
  end

  lane_merge merge_i (
    .clk          (clk),
    .rst          (rst),
    .lane_out_val (lane_out_val),
    .lane_out_rdy (lane_out_rdy),
    .lane_out_msg (lane_out_msg),
    .out_val      (out_val),
    .out_rdy      (out_rdy),
    .out_msg      (out_msg)
  );

endmodule

// ==== hw/lane_merge.sv ====
`timescale 1ns/1ps

// Round-robin merge of all lanes onto one output
module lane_merge (
  input  logic                                 clk,
  input  logic                                 rst,

  input  logic [stream_cfg_pkg::NUM_LANES-1:0] lane_out_val,
  output logic [stream_cfg_pkg::NUM_LANES-1:0] lane_out_rdy,
  input  stream_msg_pkg::stream_msg_t          lane_out_msg [stream_cfg_pkg::NUM_LANES],

  output logic                                 out_val,
  input  logic                                 out_rdy,
  output stream_msg_pkg::stream_msg_t          out_msg
);

  import stream_cfg_pkg::*;
  import stream_msg_pkg::*;

  // Last lane served
  lane_id_t rr_ptr;
  // Next lane by round-robin search
  lane_id_t pick_lane;
  // Lane driving the output now
  lane_id_t gnt_lane;
  // Grant held through a stall
  lane_id_t locked_lane;
  logic     locked;

  // --------------------------------------------------------------------
  // Arbitration
  // --------------------------------------------------------------------

  // Search starts one past rr_ptr
  // Loop runs backwards so the nearest valid lane wins
  always_comb begin
    int idx;
    pick_lane = rr_ptr;
    for (int k = NUM_LANES; k >= 1; k--) begin
      idx = (int'(rr_ptr) + k) % NUM_LANES;
      if (lane_out_val[idx]) begin
        pick_lane = lane_id_t'(idx);
      end
    end
  end

  // Locked grant overrides the search
  assign gnt_lane = locked ? locked_lane : pick_lane;

  // --------------------------------------------------------------------
  // Output mux
  // --------------------------------------------------------------------

  // No valid lane means pick_lane is rr_ptr, itself not valid
  assign out_val = lane_out_val[gnt_lane];
  assign out_msg = lane_out_msg[gnt_lane];

  // Ready only back to the granted lane
  always_comb begin
    lane_out_rdy = '0;
    lane_out_rdy[gnt_lane] = out_rdy;
  end

  // --------------------------------------------------------------------
  // Grant state
  // --------------------------------------------------------------------

  // Transfer moves the pointer and frees the lock
  // Stall freezes the current grant
  always_ff @(posedge clk) begin
    if (rst) begin
      rr_ptr      <= lane_id_t'(NUM_LANES - 1);
      locked      <= 1'b0;
      locked_lane <= '0;
    end else if (out_val && out_rdy) begin
      rr_ptr <= gnt_lane;
      locked <= 1'b0;
    end else if (out_val) begin
      locked      <= 1'b1;
      locked_lane <= gnt_lane;
    end
  end

  // --------------------------------------------------------------------
  // Checks
  // --------------------------------------------------------------------

  // Stalled grant stays on a lane that is still valid
  // relies on delay_lane holding recv_val
  a_grant_held: assert property (@(posedge clk) disable iff (rst)
    out_val && !out_rdy |=> out_val)
    else $error("lane_merge: valid dropped under stall, gnt_lane=%h", gnt_lane);

endmodule

// ==== hw/delay_lane.sv ====
`timescale 1ns/1ps

// FIFO lane with minimum spacing on both sides
module delay_lane #(
  parameter int DEPTH     = 4,
  parameter int SEND_INTV = 1,
  parameter int RECV_INTV = 2
) (
  input  logic                        clk,
  input  logic                        rst,

  input  logic                        send_val,
  output logic                        send_rdy,
  input  stream_msg_pkg::stream_msg_t send_msg,

  output logic                        recv_val,
  input  logic                        recv_rdy,
  output stream_msg_pkg::stream_msg_t recv_msg
);

  import stream_msg_pkg::*;

  // Pointer, occupancy and interval counter widths
  localparam int PTR_W  = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int CNT_W  = $clog2(DEPTH + 1);
  localparam int SCNT_W = (SEND_INTV > 0) ? $clog2(SEND_INTV + 1) : 1;
  localparam int RCNT_W = (RECV_INTV > 0) ? $clog2(RECV_INTV + 1) : 1;

  stream_msg_t       mem [DEPTH];
  logic [PTR_W-1:0]  wr_ptr;
  logic [PTR_W-1:0]  rd_ptr;
  logic [CNT_W-1:0]  count;
  logic [CNT_W-1:0]  count_next;
  logic [SCNT_W-1:0] send_cnt;
  logic [SCNT_W-1:0] send_cnt_next;
  logic [RCNT_W-1:0] recv_cnt;
  logic              push;
  logic              pop;

  assign push = send_val && send_rdy;
  assign pop  = recv_val && recv_rdy;

  // Circular pointer step, wraps at DEPTH
  function automatic logic [PTR_W-1:0] ptr_inc(input logic [PTR_W-1:0] ptr);
    if (ptr == PTR_W'(DEPTH - 1)) begin
      return '0;
    end
    return ptr + 1'b1;
  endfunction

  // --------------------------------------------------------------------
  // Storage
  // --------------------------------------------------------------------

  always_ff @(posedge clk) begin
    if (push) begin
      mem[wr_ptr] <= send_msg;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
    end else begin
      if (push) begin
        wr_ptr <= ptr_inc(wr_ptr);
      end
      if (pop) begin
        rd_ptr <= ptr_inc(rd_ptr);
      end
    end
  end

  // Occupancy after this edge
  assign count_next = count + CNT_W'(push) - CNT_W'(pop);

  // --------------------------------------------------------------------
  // Send side pacing
  // --------------------------------------------------------------------

  // Reload on acceptance, then count down to zero
  always_comb begin
    if (push) begin
      send_cnt_next = SCNT_W'(SEND_INTV);
    end else if (send_cnt != '0) begin
      send_cnt_next = send_cnt - 1'b1;
    end else begin
      send_cnt_next = send_cnt;
    end
  end

  // Ready registered from next-state values
  // Low for SEND_INTV cycles after each acceptance
  always_ff @(posedge clk) begin
    if (rst) begin
      count    <= '0;
      send_cnt <= '0;
      send_rdy <= 1'b0;
    end else begin
      count    <= count_next;
      send_cnt <= send_cnt_next;
      send_rdy <= (send_cnt_next == '0) && (count_next != CNT_W'(DEPTH));
    end
  end

  // --------------------------------------------------------------------
  // Receive side pacing
  // --------------------------------------------------------------------

  // Reload on release
  always_ff @(posedge clk) begin
    if (rst) begin
      recv_cnt <= '0;
    end else if (pop) begin
      recv_cnt <= RCNT_W'(RECV_INTV);
    end else if (recv_cnt != '0) begin
      recv_cnt <= recv_cnt - 1'b1;
    end
  end

  // Head of FIFO, held until popped
  assign recv_val = (count != '0) && (recv_cnt == '0);
  assign recv_msg = mem[rd_ptr];

  // --------------------------------------------------------------------
  // Checks
  // --------------------------------------------------------------------

  // Registered ready must already cover a full FIFO
  a_no_push_full: assert property (@(posedge clk) disable iff (rst)
    push |-> (count != CNT_W'(DEPTH)))
    else $error("delay_lane: push while full, count=%h", count);

  // Stalled output keeps its word
  a_recv_hold: assert property (@(posedge clk) disable iff (rst)
    recv_val && !recv_rdy |=> recv_val && $stable(recv_msg))
    else $error("delay_lane: recv_msg changed under stall (%h)", recv_msg);

endmodule

// ==== hw/lane_dispatch.sv ====
`timescale 1ns/1ps

// Steers the input stream to one lane
module lane_dispatch (
  input  logic                                in_val,
  output logic                                in_rdy,
  input  stream_msg_pkg::stream_msg_t         in_msg,

  output logic [stream_cfg_pkg::NUM_LANES-1:0] lane_in_val,
  input  logic [stream_cfg_pkg::NUM_LANES-1:0] lane_in_rdy,
  output stream_msg_pkg::stream_msg_t         lane_in_msg
);

  // --------------------------------------------------------------------
  // Forward path
  // --------------------------------------------------------------------

  // Same word goes to every lane
  // Only the addressed one sees a valid
  assign lane_in_msg = in_msg;

  // Lane field to one-hot valid
  always_comb begin
    lane_in_val = '0;
    lane_in_val[in_msg.lane] = in_val;
  end

  // --------------------------------------------------------------------
  // Ready return
  // --------------------------------------------------------------------

  // Addressed lane's ready straight back to the source
  // Pure mux, no state
  // Ready of the other lanes is ignored
  assign in_rdy = lane_in_rdy[in_msg.lane];

endmodule

// ==== hw/stream_msg_pkg.sv ====
// ----------------------------------------------------------------------
// Message types carried on every val/rdy link
// ----------------------------------------------------------------------

package stream_msg_pkg;

  // Lane number, selects one delay lane
  typedef logic [stream_cfg_pkg::LANE_W-1:0] lane_id_t;

  // One stream message
  // Lane field sits on top, read by the dispatcher
  // Tag and data pass through untouched
  typedef struct packed {
    lane_id_t                         lane;
    logic [stream_cfg_pkg::TAG_W-1:0]  tag;
    logic [stream_cfg_pkg::DATA_W-1:0] data;
  } stream_msg_t;

endpackage

// ==== hw/stream_cfg_pkg.sv ====
// ----------------------------------------------------------------------
// Sizing constants for the stream throttle
// ----------------------------------------------------------------------

package stream_cfg_pkg;

  // Lane count, one delay lane each
  localparam int NUM_LANES = 4;

  // Lane id width
  localparam int LANE_W = $clog2(NUM_LANES);

  // Payload width
  localparam int DATA_W = 16;

  // Sequence tag width
  // Only the testbench gives the tag any meaning
  localparam int TAG_W = 8;

endpackage
